// ==== Bender.yml ====
package:
  name: pkt_manage

sources:
  - source/pkt_format_pkg.sv
  - source/cpu_map_pkg.sv
  - source/pkt_ingress_fifo.sv
  - source/pkt_bank_ram.sv
  - source/cpu_mem_port.sv
  - source/bank_ctrl.sv
  - source/pkt_manage.sv
  - target: test
    files:
      - dv/pkt_manage_props.sv
      - dv/tb_pkt_manage.sv

// ==== pkt_manage.f ====
source/pkt_format_pkg.sv
source/cpu_map_pkg.sv
source/pkt_ingress_fifo.sv
source/pkt_bank_ram.sv
source/cpu_mem_port.sv
source/bank_ctrl.sv
source/pkt_manage.sv
dv/pkt_manage_props.sv
dv/tb_pkt_manage.sv

// ==== dv/tb_pkt_manage.sv ====
// testbench for pkt_manage, one packet in flight at a time
// lengths, payloads, cpu edits and idle gaps come from a 16-bit galois lfsr
// cpu never writes a word that the packet port writes in the same cycle
`timescale 1ns/1ps

module tb_pkt_manage import pkt_format_pkg::*, cpu_map_pkg::*; ();

	localparam int CLK_PERIOD  = 8;   // ns
	localparam int RST_CYCLES  = 16;
	localparam int NUM_PKTS    = 12;
	localparam int HOLD_CYCLES = 200;
	localparam int PKT_BUDGET  = 2 * BANK_DEPTH + 64;  // beats in and out, cpu traffic, polling
	localparam int START_LIMIT = 40;  // done write to first beat

	logic              clk;
	logic              rst_n;
	logic              i_pkt_valid;
	logic [PKT_W-1:0]  i_pkt_data;
	logic              o_pkt_valid;
	logic [PKT_W-1:0]  o_pkt_data;
	logic              i_mem_wren;
	logic              i_mem_rden;
	logic [MEM_AW-1:0] i_mem_addr;
	logic [LANE_W-1:0] i_mem_wdata;
	logic [LANE_W-1:0] o_mem_rdata;

	logic [15:0]       lfsr_state;
	logic [PKT_W-1:0]  shadow [NUM_BANKS][BANK_DEPTH];  // expected bank contents
	int                plen [NUM_BANKS];
	int                order_q [$];  // banks in arrival order

	pkt_manage pkt_manage_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_pkt_valid (i_pkt_valid),
		.i_pkt_data  (i_pkt_data),
		.o_pkt_valid (o_pkt_valid),
		.o_pkt_data  (o_pkt_data),
		.i_mem_wren  (i_mem_wren),
		.i_mem_rden  (i_mem_rden),
		.i_mem_addr  (i_mem_addr),
		.i_mem_wdata (i_mem_wdata),
		.o_mem_rdata (o_mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic lfsr_step();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 16'hB400;
		return lsb;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	function automatic logic [MEM_AW-1:0] cpu_addr(int bank, int word, int lane);
		return MEM_AW'((bank << BANK_LSB) | (word << WORD_LSB) | (lane << LANE_LSB));
	endfunction

	// lane 3 is the bottom 32 payload bits
	function automatic logic [LANE_W-1:0] lane_of(logic [PKT_W-1:0] word, int lane);
		return word[(NUM_LANES - 1 - lane) * LANE_W +: LANE_W];
	endfunction

	task automatic check(string name, logic [PKT_W-1:0] exp, logic [PKT_W-1:0] act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic cpu_write(int bank, int word, int lane, logic [LANE_W-1:0] data);
		@(posedge clk);
		i_mem_wren  <= 1'b1;
		i_mem_addr  <= cpu_addr(bank, word, lane);
		i_mem_wdata <= data;
		@(posedge clk);
		i_mem_wren  <= 1'b0;
		shadow[bank][word][(NUM_LANES - 1 - lane) * LANE_W +: LANE_W] = data;  // model follows
	endtask

	task automatic read_lane(string name, int bank, int word, int lane, logic [LANE_W-1:0] exp);
		@(posedge clk);
		i_mem_rden <= 1'b1;
		i_mem_addr <= cpu_addr(bank, word, lane);
		@(posedge clk);
		i_mem_rden <= 1'b0;
		@(posedge clk);
		@(negedge clk);  // result settled after the second edge
		check(name, exp, o_mem_rdata);
	endtask

	// head, bodies, tail with random control nibble and payload
	task automatic make_packet(int bank, int len);
		logic [PAYLOAD_W-1:0] pl;
		logic [3:0]           ctl;
		beat_type_e           bt;
		for (int i = 0; i < len; i++) begin
			pl  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
			ctl = 4'(rand_bits(4));
			bt  = (i == 0) ? HEAD : ((i == len - 1) ? TAIL : BODY);
			if (i == 0)
				pl[CPU_DONE_BIT] = 1'b0;  // done stays clear until the cpu sets it
			shadow[bank][i] = {bt, ctl, pl};
		end
		plen[bank] = len;
	endtask

	task automatic send_packet(int bank, int len);
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			i_pkt_valid <= 1'b1;  // back to back beats
			i_pkt_data  <= shadow[bank][i];
		end
		@(posedge clk);
		i_pkt_valid <= 1'b0;
	endtask

	task automatic wait_first_beat();
		int n;
		n = 0;
		@(negedge clk);
		while (o_pkt_valid !== 1'b1) begin
			if (n == START_LIMIT) begin
				$display("no packet left the DUT within %0d cycles of setting done", n);
				$display("Some tests failed");
				$fatal(1, "egress timeout");
			end
			n++;
			@(negedge clk);
		end
	endtask

	initial begin
		int                bank;
		int                len;
		int                word;
		int                lane;
		int                ob;
		logic [LANE_W-1:0] val;
		lfsr_state  = 16'd5263;
		rst_n       = 1'b0;
		i_pkt_valid = 1'b0;
		i_pkt_data  = '0;
		i_mem_wren  = 1'b0;
		i_mem_rden  = 1'b0;
		i_mem_addr  = '0;
		i_mem_wdata = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("reset_valid", 0, o_pkt_valid);
		check("reset_rdata", 0, o_mem_rdata);

		for (int k = 0; k < NUM_PKTS; k++) begin
			bank = k % NUM_BANKS;  // strict rotation
			len  = 2 + int'(rand_bits(5)) % 31;
			make_packet(bank, len);
			repeat (rand_bits(3)) @(posedge clk);  // idle gap
			send_packet(bank, len);
			repeat (4) @(posedge clk);  // stored within 5 edges of the tail
			order_q.push_back(bank);

			// packet k must sit in bank k mod 3
			read_lane("rotation_head", bank, 0, 3, lane_of(shadow[bank][0], 3));
			read_lane("rotation_tail", bank, len - 1, 0, lane_of(shadow[bank][len - 1], 0));

			// one random lane edit, neighbour untouched
			word = int'(rand_bits(5)) % len;
			lane = int'(rand_bits(2));
			val  = rand_bits(32);
			if (word == 0 && lane == 3)
				val[CPU_DONE_BIT] = 1'b0;
			read_lane("readback", bank, word, lane, lane_of(shadow[bank][word], lane));
			cpu_write(bank, word, lane, val);
			read_lane("edit_new", bank, word, lane, val);
			read_lane("edit_other", bank, word, lane ^ 1, lane_of(shadow[bank][word], lane ^ 1));

			if (k == 0) begin
				for (int c = 0; c < HOLD_CYCLES; c++) begin
					@(negedge clk);
					check("hold_until_done", 0, o_pkt_valid);
				end
			end

			val = lane_of(shadow[bank][0], 3);
			val[CPU_DONE_BIT] = 1'b1;
			cpu_write(bank, 0, 3, val);
			wait_first_beat();
			ob = order_q.pop_front();
			for (int i = 0; i < plen[ob]; i++) begin
				check("beat_valid", 1, o_pkt_valid);  // no gaps inside a packet
				check("beat_data", shadow[ob][i], o_pkt_data);
				@(negedge clk);
			end
			check("tail_type", TAIL, o_pkt_data[BEAT_TYPE_MSB:BEAT_TYPE_LSB]);
			check("after_tail", 0, o_pkt_valid);

			// word 0 zeroed once sent
			repeat (3) @(posedge clk);
			for (int l = 0; l < NUM_LANES; l++)
				read_lane("clear_word0", ob, 0, l, '0);
		end

		$display("All tests passed");
		$finish;
	end

	// watch the bound checker
	initial begin
		wait (pkt_manage_inst.pkt_manage_props_inst.fail_count != 0);
		check("bound_assertions", 0, pkt_manage_inst.pkt_manage_props_inst.fail_count);
	end

	// budget per packet plus the hold window and reset
	initial begin
		#((NUM_PKTS * PKT_BUDGET + HOLD_CYCLES + RST_CYCLES) * CLK_PERIOD);
		$display("watchdog expired before all packets were checked");
		$display("Some tests failed");
		$fatal(1, "watchdog timeout");
	end

endmodule

// ==== dv/pkt_manage_props.sv ====
// concurrent checks bound into pkt_manage
// reaches into bank_ctrl_inst for the per-FSM write strobes and bank indices
`timescale 1ns/1ps

module pkt_manage_props import pkt_format_pkg::*; (
	input logic             clk,
	input logic             rst_n,
	input logic             i_ing_we,
	input logic             i_egr_clear,
	input bank_sel_t        i_wr_sel,
	input bank_sel_t        i_rd_sel,
	input logic             i_pkt_valid,
	input logic [PKT_W-1:0] i_pkt_data
);

	logic head_out;
	logic tail_out;
	logic in_pkt;  // between an output head and its tail
	int   fail_count = 0;  // assertion failures so far

	assign head_out = i_pkt_valid && (i_pkt_data[BEAT_TYPE_MSB:BEAT_TYPE_LSB] == HEAD);
	assign tail_out = i_pkt_valid && (i_pkt_data[BEAT_TYPE_MSB:BEAT_TYPE_LSB] == TAIL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			in_pkt <= 1'b0;
		else if (head_out)
			in_pkt <= 1'b1;
		else if (tail_out)
			in_pkt <= 1'b0;  // packet closed
	end

	// fill and clear never hit one bank together
	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_ing_we && i_egr_clear && (i_wr_sel == i_rd_sel)))
		else begin
			fail_count++;
			$error("ingress and egress wrote bank %0d in the same cycle", i_wr_sel);
		end

	a_head_framing: assert property (@(posedge clk) disable iff (!rst_n)
		head_out |-> !in_pkt)
		else begin
			fail_count++;
			$error("HEAD beat on the output before the previous TAIL");
		end

	// from the second edge in reset on
	a_reset_quiet: assert property (@(posedge clk)
		(!rst_n && $past(!rst_n)) |-> !i_pkt_valid)
		else begin
			fail_count++;
			$error("o_pkt_valid high during reset");
		end

endmodule

bind pkt_manage pkt_manage_props pkt_manage_props_inst (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_ing_we    (bank_ctrl_inst.ing_we),
	.i_egr_clear (bank_ctrl_inst.egr_clear),
	.i_wr_sel    (bank_ctrl_inst.wr_sel),
	.i_rd_sel    (bank_ctrl_inst.rd_sel),
	.i_pkt_valid (o_pkt_valid),
	.i_pkt_data  (o_pkt_data)
);

// ==== source/pkt_manage.sv ====
// packet buffer manager top, wiring only
// no back-pressure, beats are lost when the ingress fifo is full
// packets leave in arrival order once the cpu sets the done flag
`timescale 1ns/1ps

module pkt_manage import pkt_format_pkg::*, cpu_map_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_pkt_valid,
	input  logic [PKT_W-1:0]  i_pkt_data,
	output logic              o_pkt_valid,
	output logic [PKT_W-1:0]  o_pkt_data,
	input  logic              i_mem_wren,
	input  logic              i_mem_rden,
	input  logic [MEM_AW-1:0] i_mem_addr,
	input  logic [LANE_W-1:0] i_mem_wdata,
	output logic [LANE_W-1:0] o_mem_rdata
);

	logic                                fifo_rd;
	logic                                fifo_empty;
	logic [PKT_W-1:0]                    fifo_data;
	logic [NUM_BANKS-1:0]                bank_we;
	logic [NUM_BANKS-1:0][BANK_AW-1:0]   bank_addr;
	logic [PKT_W-1:0]                    bank_wdata;   // shared by all banks
	logic [NUM_BANKS-1:0][PKT_W-1:0]     bank_rdata;
	logic [NUM_BANKS-1:0][NUM_LANES-1:0] lane_we;
	logic [BANK_AW-1:0]                  cpu_word;
	logic [LANE_W-1:0]                   cpu_wdata;
	logic [NUM_BANKS-1:0][PAYLOAD_W-1:0] cpu_rdata;

	pkt_ingress_fifo pkt_ingress_fifo_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_wr_en   (i_pkt_valid),
		.i_wr_data (i_pkt_data),
		.i_rd_en   (fifo_rd),
		.o_rd_data (fifo_data),
		.o_empty   (fifo_empty)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		pkt_bank_ram pkt_bank_ram_inst (
			.clk           (clk),
			.i_pkt_we      (bank_we[b]),
			.i_pkt_addr    (bank_addr[b]),
			.i_pkt_wdata   (bank_wdata),
			.o_pkt_rdata   (bank_rdata[b]),
			.i_cpu_lane_we (lane_we[b]),
			.i_cpu_addr    (cpu_word),
			.i_cpu_wdata   (cpu_wdata),
			.o_cpu_rdata   (cpu_rdata[b])
		);
	end

	cpu_mem_port cpu_mem_port_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_mem_wren   (i_mem_wren),
		.i_mem_rden   (i_mem_rden),
		.i_mem_addr   (i_mem_addr),
		.i_mem_wdata  (i_mem_wdata),
		.o_lane_we    (lane_we),
		.o_word_addr  (cpu_word),
		.o_wdata      (cpu_wdata),
		.i_bank_rdata (cpu_rdata),
		.o_mem_rdata  (o_mem_rdata)
	);

	bank_ctrl bank_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_fifo_empty (fifo_empty),
		.i_fifo_data  (fifo_data),
		.o_fifo_rd    (fifo_rd),
		.o_bank_we    (bank_we),
		.o_bank_addr  (bank_addr),
		.o_bank_wdata (bank_wdata),
		.i_bank_rdata (bank_rdata),
		.o_pkt_valid  (o_pkt_valid),
		.o_pkt_data   (o_pkt_data)
	);

endmodule

// ==== source/bank_ctrl.sv ====
// bank rotation, ingress and egress FSMs, registered output
// banks fill and drain in strict order 0,1,2
// egress polls the done flag in word 0, streams to TAIL, then clears word 0
// ingress skips one read ahead of the clear since wdata is shared
`timescale 1ns/1ps

module bank_ctrl import pkt_format_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              i_fifo_empty,
	input  logic [PKT_W-1:0]                  i_fifo_data,
	output logic                              o_fifo_rd,
	output logic [NUM_BANKS-1:0]              o_bank_we,
	output logic [NUM_BANKS-1:0][BANK_AW-1:0] o_bank_addr,
	output logic [PKT_W-1:0]                  o_bank_wdata,
	input  logic [NUM_BANKS-1:0][PKT_W-1:0]   i_bank_rdata,
	output logic                              o_pkt_valid,
	output logic [PKT_W-1:0]                  o_pkt_data
);

	bank_state_e        bank_state [NUM_BANKS];
	bank_sel_t          wr_sel;     // bank being filled
	bank_sel_t          rd_sel;     // bank being polled or sent
	ingress_state_e     ing_state;
	egress_state_e      egr_state;
	logic [BANK_AW-1:0] wr_addr;
	logic [BANK_AW-1:0] egr_addr;
	logic               rd_v;       // fifo q holds a fresh beat
	logic               ing_we;
	logic               ing_tail;
	logic [PKT_W-1:0]   egr_word;
	logic               egr_done;
	logic               egr_send;   // beat goes out next edge
	logic               egr_last;   // that beat is the tail
	logic               egr_clear;

	function automatic bank_sel_t next_bank(bank_sel_t sel);
		return (sel == bank_sel_t'(NUM_BANKS - 1)) ? bank_sel_t'(0) : sel + 1'b1;
	endfunction

	assign ing_we   = (ing_state == ING_WRITE) && rd_v;
	assign ing_tail = ing_we &&
		(beat_type_e'(i_fifo_data[BEAT_TYPE_MSB:BEAT_TYPE_LSB]) == TAIL);

	assign egr_word  = i_bank_rdata[rd_sel];
	assign egr_done  = egr_word[CPU_DONE_BIT];
	assign egr_send  = (egr_state == EGR_SEND) || ((egr_state == EGR_POLL) && egr_done);
	assign egr_last  = egr_send &&
		(beat_type_e'(egr_word[BEAT_TYPE_MSB:BEAT_TYPE_LSB]) == TAIL);
	assign egr_clear = (egr_state == EGR_CLEAR);

	// read one beat per cycle, never past a tail
	assign o_fifo_rd = !i_fifo_empty && !egr_last &&
		(((ing_state == ING_IDLE) && (bank_state[wr_sel] == EMPTY)) ||
		((ing_state == ING_WRITE) && !ing_tail));

	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			o_bank_we[b] = (ing_we && (wr_sel == bank_sel_t'(b))) ||
				(egr_clear && (rd_sel == bank_sel_t'(b)));
			o_bank_addr[b] = ((ing_state == ING_WRITE) && (wr_sel == bank_sel_t'(b))) ?
				wr_addr : egr_addr;
		end
	end
	assign o_bank_wdata = egr_clear ? '0 : i_fifo_data;  // clear zeroes word 0

	// ingress FSM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ing_state <= ING_IDLE;
			wr_addr   <= '0;
			wr_sel    <= '0;
			rd_v      <= 1'b0;
		end else begin
			rd_v <= o_fifo_rd;  // fifo latency is one
			case (ing_state)
				ING_IDLE: begin
					wr_addr <= '0;
					if (o_fifo_rd)
						ing_state <= ING_WRITE;
				end
				ING_WRITE: begin
					if (ing_we)
						wr_addr <= wr_addr + 1'b1;
					if (ing_tail) begin
						wr_sel    <= next_bank(wr_sel);
						ing_state <= ING_IDLE;
					end
				end
				default: ing_state <= ING_IDLE;
			endcase
		end
	end

	// egress FSM, issue, wait, inspect, then stream
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			egr_state   <= EGR_IDLE;
			egr_addr    <= '0;
			rd_sel      <= '0;
			o_pkt_valid <= 1'b0;
		end else begin
			o_pkt_valid <= egr_send;
			case (egr_state)
				EGR_IDLE: begin
					egr_addr <= '0;  // issue word 0
					if (bank_state[rd_sel] == FILLED)
						egr_state <= EGR_WAIT;
				end
				EGR_WAIT: begin
					egr_addr  <= egr_addr + 1'b1;  // word 0 in flight
					egr_state <= EGR_POLL;
				end
				EGR_POLL: begin
					if (!egr_done)
						egr_state <= EGR_IDLE;  // not yet, poll again
					else if (egr_last) begin
						egr_addr  <= '0;
						egr_state <= EGR_CLEAR;
					end else begin
						egr_addr  <= egr_addr + 1'b1;
						egr_state <= EGR_SEND;
					end
				end
				EGR_SEND: begin
					if (egr_last) begin
						egr_addr  <= '0;  // point at word 0 for the clear
						egr_state <= EGR_CLEAR;
					end else
						egr_addr <= egr_addr + 1'b1;
				end
				EGR_CLEAR: begin
					rd_sel    <= next_bank(rd_sel);
					egr_state <= EGR_IDLE;
				end
				default: egr_state <= EGR_IDLE;
			endcase
		end
	end

	// fill and free flags, fsms never target the same bank
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < NUM_BANKS; b++)
				bank_state[b] <= EMPTY;
		end else begin
			if (ing_tail)
				bank_state[wr_sel] <= FILLED;
			if (egr_clear)
				bank_state[rd_sel] <= EMPTY;
		end
	end

	always_ff @(posedge clk) begin
		if (egr_send)
			o_pkt_data <= egr_word;  // beat as stored, cpu edits included
	end

endmodule

// ==== source/cpu_mem_port.sv ====
// cpu lane access to the three banks
// writes land at the next edge, reads show two edges after i_mem_rden
// o_mem_rdata holds the last read result, bank 3 reads as zero
`timescale 1ns/1ps

module cpu_mem_port import pkt_format_pkg::*, cpu_map_pkg::*; (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                i_mem_wren,
	input  logic                                i_mem_rden,
	input  logic [MEM_AW-1:0]                   i_mem_addr,
	input  logic [LANE_W-1:0]                   i_mem_wdata,
	output logic [NUM_BANKS-1:0][NUM_LANES-1:0] o_lane_we,
	output logic [BANK_AW-1:0]                  o_word_addr,
	output logic [LANE_W-1:0]                   o_wdata,
	input  logic [NUM_BANKS-1:0][PAYLOAD_W-1:0] i_bank_rdata,
	output logic [LANE_W-1:0]                   o_mem_rdata
);

	bank_sel_t             addr_bank;  // decoded from live address
	logic [LANE_SEL_W-1:0] addr_lane;
	logic                  rd_q;       // stage 1, bank read in flight
	bank_sel_t             rd_bank_q;
	logic [LANE_SEL_W-1:0] rd_lane_q;
	logic [LANE_W-1:0]     lane_word;

	assign addr_bank   = i_mem_addr[BANK_LSB +: $bits(bank_sel_t)];
	assign addr_lane   = i_mem_addr[LANE_LSB +: LANE_SEL_W];
	assign o_word_addr = i_mem_addr[WORD_LSB +: BANK_AW];  // shared by all banks
	assign o_wdata     = i_mem_wdata;

	// one-hot lane write enable
	always_comb begin
		o_lane_we = '0;
		if (i_mem_wren && (addr_bank < NUM_BANKS))  // unmapped bank ignored
			o_lane_we[addr_bank][addr_lane] = 1'b1;
	end

	// pick the lane from the word the bank returned
	always_comb begin
		lane_word = '0;
		if (rd_bank_q < NUM_BANKS)
			lane_word = i_bank_rdata[rd_bank_q][PAYLOAD_W-1-rd_lane_q*LANE_W -: LANE_W];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_q        <= 1'b0;
			rd_bank_q   <= '0;
			rd_lane_q   <= '0;
			o_mem_rdata <= '0;
		end else begin
			rd_q      <= i_mem_rden;
			rd_bank_q <= addr_bank;  // lines up with bank read latency
			rd_lane_q <= addr_lane;
			if (rd_q)
				o_mem_rdata <= lane_word;  // stage 2, held until next read
		end
	end

endmodule

// ==== source/pkt_bank_ram.sv ====
// one packet bank, BANK_DEPTH words of PKT_W bits
// packet port reads and writes whole words, cpu port writes single lanes
// cpu port never touches the beat type bits
// same word on both ports in one cycle is undefined
`timescale 1ns/1ps

module pkt_bank_ram import pkt_format_pkg::*, cpu_map_pkg::*; (
	input  logic                 clk,
	input  logic                 i_pkt_we,
	input  logic [BANK_AW-1:0]   i_pkt_addr,
	input  logic [PKT_W-1:0]     i_pkt_wdata,
	output logic [PKT_W-1:0]     o_pkt_rdata,
	input  logic [NUM_LANES-1:0] i_cpu_lane_we,
	input  logic [BANK_AW-1:0]   i_cpu_addr,
	input  logic [LANE_W-1:0]    i_cpu_wdata,
	output logic [PAYLOAD_W-1:0] o_cpu_rdata
);

	logic [PKT_W-1:0] mem [BANK_DEPTH];

	// single process, both ports write the same array
	always_ff @(posedge clk) begin
		if (i_pkt_we)
			mem[i_pkt_addr] <= i_pkt_wdata;  // whole beat incl. type
		for (int l = 0; l < NUM_LANES; l++) begin
			// lane 0 sits at the top of the payload
			if (i_cpu_lane_we[l])
				mem[i_cpu_addr][PAYLOAD_W-1-l*LANE_W -: LANE_W] <= i_cpu_wdata;
		end
		o_pkt_rdata <= mem[i_pkt_addr];  // read before write
		o_cpu_rdata <= mem[i_cpu_addr][PAYLOAD_W-1:0];
	end

endmodule

// ==== source/pkt_ingress_fifo.sv ====
// synchronous fifo for incoming beats, FIFO_DEPTH entries
// writes while full are lost, reads while empty are ignored
// read data is registered, valid one cycle after i_rd_en
`timescale 1ns/1ps

module pkt_ingress_fifo import pkt_format_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_wr_en,
	input  logic [PKT_W-1:0] i_wr_data,
	input  logic             i_rd_en,
	output logic [PKT_W-1:0] o_rd_data,
	output logic             o_empty
);

	logic [PKT_W-1:0]   mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;  // wraps at depth
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;   // one extra bit for full
	logic               do_wr;
	logic               do_rd;

	assign o_empty = (count == '0);
	assign do_wr   = i_wr_en && (count != (FIFO_AW + 1)'(FIFO_DEPTH));  // drop when full
	assign do_rd   = i_rd_en && !o_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	// storage and read register
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= i_wr_data;
		if (do_rd)
			o_rd_data <= mem[rd_ptr];
	end

endmodule

// ==== source/cpu_map_pkg.sv ====
// cpu address map, 9-bit lane address
// [8:7] bank, [6:2] word, [1:0] lane
// lane 0 is payload bits 127:96, lane 3 is bits 31:0
// bank field value 3 is unmapped
package cpu_map_pkg;

	localparam int MEM_AW     = 9;
	localparam int LANE_W     = 32;
	localparam int NUM_LANES  = 4;
	localparam int LANE_SEL_W = 2;  // width of the lane field

	// field positions in the cpu address
	localparam int LANE_LSB = 0;
	localparam int WORD_LSB = 2;
	localparam int BANK_LSB = 7;

endpackage

// ==== source/pkt_format_pkg.sv ====
// beat format, bank geometry and controller state encodings
// beats are 134 bits, top two bits give the beat type
// each bank holds exactly one packet of up to BANK_DEPTH beats
package pkt_format_pkg;

	localparam int PKT_W         = 134;
	localparam int PAYLOAD_W     = 128;  // cpu visible part of a beat
	localparam int BEAT_TYPE_MSB = 133;
	localparam int BEAT_TYPE_LSB = 132;

	typedef enum logic [1:0] {
		BODY = 2'b00,
		HEAD = 2'b01,
		TAIL = 2'b10
	} beat_type_e;

	localparam int NUM_BANKS    = 3;
	localparam int BANK_DEPTH   = 32;
	localparam int BANK_AW      = 5;
	typedef logic [1:0] bank_sel_t;  // value 3 never used
	localparam int CPU_DONE_BIT = 1;  // done flag, word 0

	localparam int FIFO_DEPTH   = 64;
	localparam int FIFO_AW      = 6;

	typedef enum logic {EMPTY = 1'b0, FILLED = 1'b1} bank_state_e;
	typedef enum logic {ING_IDLE, ING_WRITE} ingress_state_e;
	typedef enum logic [2:0] {EGR_IDLE, EGR_WAIT, EGR_POLL, EGR_SEND, EGR_CLEAR} egress_state_e;

endpackage
